// ==== tb.f ====
mips_pkg.sv
pipe_ifs.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
operand_forward.sv
execute_stage.sv
memory_stage.sv
mips_core.sv
tb_mips_core.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_mips_core -o tb_sim

out=$(./obj_dir/tb_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1

// ==== tb_mips_core.sv ====
// Directed testbench for the pipelined MIPS core with an instruction memory model
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*; ();
    localparam int MAX_CYCLES = 400;        // Five tests take about 130 cycles
    localparam int WAIT_LIMIT = 80;         // Per-test wait for write-backs
    localparam int DRAIN      = 6;          // Longer than the pipeline

    logic     clk;
    logic     reset;
    word_t    imem_data;
    word_t    imem_addr;
    logic     wb_write;
    reg_idx_t wb_dest;
    word_t    wb_data;

    word_t    imem [256];                   // Program words rewritten before each test
    reg_idx_t exp_dest [$];
    word_t    exp_val  [$];
    reg_idx_t got_dest [$];
    word_t    got_val  [$];
    time      got_time [$];
    int       cycle_count = 0;
    int       test_count  = 0;
    int       error_count = 0;

    mips_core uut (
        .clk       (clk),
        .reset     (reset),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .wb_write  (wb_write),
        .wb_dest   (wb_dest),
        .wb_data   (wb_data)
    );

    // Combinational instruction memory with no-ops past the end
    assign imem_data = (imem_addr < 32'd1024) ? imem[imem_addr[9:2]] : '0;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Write-back trace sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && wb_write) begin
            got_dest.push_back(wb_dest);
            got_val.push_back(wb_data);
            got_time.push_back($time);
        end
    end

    // ============================================================
    // Run limit
    // ============================================================
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles before the tests finished", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // ============================================================
    // Instruction encoders and sequencing helpers
    // ============================================================
    function automatic word_t r_format(input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] rd, input logic [5:0] funct);
        return {6'h00, rs, rt, rd, 5'h00, funct};
    endfunction

    function automatic word_t i_format(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_format(input logic [25:0] word_idx);
        return {OP_J, word_idx};            // Target is a word index
    endfunction

    task automatic hold_reset();
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;                   // All-zero word is a no-op
        end
        exp_dest.delete();
        exp_val.delete();
    endtask

    task automatic release_reset();
        @(posedge clk);                     // First reset edge
        @(posedge clk);                     // Second reset edge
        reset <= 1'b0;
        got_dest.delete();
        got_val.delete();
        got_time.delete();
    endtask

    task automatic expect_wb(input reg_idx_t dest, input word_t val);
        exp_dest.push_back(dest);
        exp_val.push_back(val);
    endtask

    task automatic compare_trace(input string name);
        int n;
        int waited;
        int errs;
        n      = exp_dest.size();
        waited = 0;
        errs   = 0;
        while ((got_dest.size() < n) && (waited < WAIT_LIMIT)) begin
            @(posedge clk);
            waited++;
        end
        repeat (DRAIN) @(posedge clk);      // Catch late or extra write-backs
        if (got_dest.size() != n) begin
            $display("%s: expected %0d write-backs but saw %0d", name, n, got_dest.size());
            errs++;
        end
        for (int i = 0; (i < n) && (i < got_dest.size()); i++) begin
            if (got_dest[i] !== exp_dest[i]) begin
                $display("[FAIL] %0t %s wb_dest #%0d expected %0d got %0d",
                         got_time[i], name, i, exp_dest[i], got_dest[i]);
                errs++;
            end
            if (got_val[i] !== exp_val[i]) begin
                $display("[FAIL] %0t %s wb_data #%0d expected %h got %h",
                         got_time[i], name, i, exp_val[i], got_val[i]);
                errs++;
            end
        end
        test_count++;
        error_count += errs;
        if (errs == 0) begin
            $display("%s: ok, %0d write-backs in order", name, n);
        end else begin
            $display("%s: %0d errors", name, errs);
        end
    endtask

    // ============================================================
    // Tests
    // ============================================================
    task automatic alu_ops_test();
        hold_reset();
        imem[0]  = i_format(OP_ADDIU, 5'd0, 5'd1, 16'h1234);
        imem[1]  = i_format(OP_ORI,   5'd0, 5'd2, 16'h8001);  // Zero extended
        imem[2]  = i_format(OP_LUI,   5'd0, 5'd3, 16'habcd);
        imem[3]  = i_format(OP_ADDIU, 5'd0, 5'd4, 16'hfffd);  // -3
        imem[4]  = i_format(OP_ADDIU, 5'd0, 5'd0, 16'h0005);  // Dropped for register zero
        imem[5]  = r_format(5'd1, 5'd2, 5'd5, FN_ADDU);
        imem[6]  = r_format(5'd2, 5'd1, 5'd6, FN_SUBU);
        imem[7]  = r_format(5'd3, 5'd4, 5'd7, FN_AND);
        imem[8]  = r_format(5'd1, 5'd3, 5'd8, FN_OR);
        imem[9]  = r_format(5'd4, 5'd1, 5'd9, FN_SLT);        // -3 < 0x1234
        imem[10] = r_format(5'd1, 5'd4, 5'd10, FN_SLT);
        imem[11] = i_format(OP_ANDI,  5'd4, 5'd11, 16'hff0f);
        release_reset();
        expect_wb(5'd1,  32'h0000_1234);
        expect_wb(5'd2,  32'h0000_8001);
        expect_wb(5'd3,  32'habcd_0000);
        expect_wb(5'd4,  32'hffff_fffd);
        expect_wb(5'd5,  32'h0000_9235);
        expect_wb(5'd6,  32'h0000_6dcd);
        expect_wb(5'd7,  32'habcd_0000);
        expect_wb(5'd8,  32'habcd_1234);
        expect_wb(5'd9,  32'h0000_0001);
        expect_wb(5'd10, 32'h0000_0000);
        expect_wb(5'd11, 32'h0000_ff0d);
        compare_trace("alu_ops");
    endtask

    task automatic forwarding_test();
        word_t r [8];
        hold_reset();
        imem[0] = i_format(OP_ADDIU, 5'd0, 5'd1, 16'h7ff3);
        imem[1] = r_format(5'd1, 5'd1, 5'd2, FN_ADDU);        // Distance one
        imem[2] = r_format(5'd2, 5'd1, 5'd3, FN_ADDU);        // One and two
        imem[3] = r_format(5'd3, 5'd1, 5'd4, FN_ADDU);        // One and three
        imem[4] = r_format(5'd4, 5'd2, 5'd5, FN_ADDU);
        imem[5] = r_format(5'd5, 5'd3, 5'd6, FN_SUBU);
        imem[6] = r_format(5'd6, 5'd5, 5'd7, FN_ADDU);
        // Sequential evaluation of the same chain
        r[1] = 32'h0000_7ff3;
        r[2] = r[1] + r[1];
        r[3] = r[2] + r[1];
        r[4] = r[3] + r[1];
        r[5] = r[4] + r[2];
        r[6] = r[5] - r[3];
        r[7] = r[6] + r[5];
        release_reset();
        for (int k = 1; k < 8; k++) begin
            expect_wb(reg_idx_t'(k), r[k]);
        end
        compare_trace("forwarding");
    endtask

    task automatic memory_test();
        hold_reset();
        imem[0] = i_format(OP_ADDIU, 5'd0, 5'd1, 16'h0040);  // Base address
        imem[1] = i_format(OP_LUI,   5'd0, 5'd2, 16'h1234);
        imem[2] = i_format(OP_ORI,   5'd2, 5'd2, 16'h5678);
        imem[3] = i_format(OP_SW,    5'd1, 5'd2, 16'h0004);
        imem[4] = i_format(OP_LW,    5'd1, 5'd3, 16'h0004);
        imem[5] = r_format(5'd3, 5'd1, 5'd4, FN_ADDU);        // Load-use
        release_reset();
        expect_wb(5'd1, 32'h0000_0040);
        expect_wb(5'd2, 32'h1234_0000);
        expect_wb(5'd2, 32'h1234_5678);
        expect_wb(5'd3, 32'h1234_5678);
        expect_wb(5'd4, 32'h1234_56b8);
        compare_trace("memory");
    endtask

    task automatic control_flow_test();
        hold_reset();
        imem[0]  = i_format(OP_ADDIU, 5'd0, 5'd1, 16'h0005);
        imem[1]  = i_format(OP_ADDIU, 5'd0, 5'd2, 16'h0005);
        imem[2]  = i_format(OP_BEQ,   5'd1, 5'd2, 16'h0002);  // Taken to word 5
        imem[3]  = i_format(OP_ADDIU, 5'd0, 5'd3, 16'h0011);  // Flushed
        imem[4]  = i_format(OP_ADDIU, 5'd0, 5'd4, 16'h0022);  // Flushed
        imem[5]  = i_format(OP_ADDIU, 5'd0, 5'd5, 16'h0033);
        imem[6]  = j_format(26'd10);
        imem[7]  = i_format(OP_ADDIU, 5'd0, 5'd6, 16'h0044);  // Flushed
        imem[8]  = i_format(OP_ADDIU, 5'd0, 5'd7, 16'h0055);  // Flushed
        imem[9]  = i_format(OP_ADDIU, 5'd0, 5'd8, 16'h0066);  // Skipped
        imem[10] = i_format(OP_BNE,   5'd1, 5'd2, 16'h0002);  // Not taken
        imem[11] = i_format(OP_ADDIU, 5'd0, 5'd9, 16'h0077);
        imem[12] = i_format(OP_ADDIU, 5'd0, 5'd10, 16'h0088);
        release_reset();
        expect_wb(5'd1,  32'h0000_0005);
        expect_wb(5'd2,  32'h0000_0005);
        expect_wb(5'd5,  32'h0000_0033);
        expect_wb(5'd9,  32'h0000_0077);
        expect_wb(5'd10, 32'h0000_0088);
        compare_trace("control_flow");
    endtask

    task automatic random_imm_test();
        logic [15:0] imm;
        word_t       rnd;
        word_t       sum;
        hold_reset();
        sum = '0;
        for (int k = 0; k < 20; k++) begin
            rnd     = $urandom();
            imm     = rnd[15:0];
            imem[k] = i_format(OP_ADDIU, (k == 0) ? 5'd0 : 5'd1, 5'd1, imm);
            sum     = sum + {{16{imm[15]}}, imm};   // Wraps modulo 2**32
            expect_wb(5'd1, sum);
        end
        release_reset();
        compare_trace("random_imm");
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        reset = 1'b1;
        void'($urandom(38));
        alu_ops_test();
        forwarding_test();
        memory_test();
        control_flow_test();
        random_imm_test();
        $display("%0d tests run, %0d failed checks", test_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== mips_core.sv ====
// Five-stage integer MIPS core top level with write-back trace ports
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  word_t    imem_data,
    output word_t    imem_addr,
    output logic     wb_write,
    output reg_idx_t wb_dest,
    output word_t    wb_data
);
    issue_if  issue ();
    bypass_if bypass ();

    word_t                  id_inst;
    word_t                  id_pc_plus4;
    logic                   id_valid;
    logic                   redirect;
    word_t                  redirect_pc;
    logic                   load_use_stall;
    reg_idx_t [NUM_SRC-1:0] rf_idx;
    word_t    [NUM_SRC-1:0] rf_data;
    word_t    [NUM_SRC-1:0] operand;
    logic     [NUM_SRC-1:0] src_stall;
    ctrl_t                  mem_ctrl;
    word_t                  mem_addr;
    word_t                  mem_wdata;
    reg_idx_t               mem_dest;

    // ============================================================
    // Front end
    // ============================================================
    fetch_stage u_fetch (
        .clk            (clk),
        .reset          (reset),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .load_use_stall (load_use_stall),
        .imem_data      (imem_data),
        .imem_addr      (imem_addr),
        .id_inst        (id_inst),
        .id_pc_plus4    (id_pc_plus4),
        .id_valid       (id_valid)
    );

    decode_stage u_decode (
        .id_inst     (id_inst),
        .id_pc_plus4 (id_pc_plus4),
        .id_valid    (id_valid),
        .rf_data     (rf_data),
        .rf_idx      (rf_idx),
        .issue       (issue.dec)
    );

    register_file u_regs (
        .clk     (clk),
        .reset   (reset),
        .rd_idx  (rf_idx),
        .wr_en   (wb_write),                // Write port fed by MEM/WB
        .wr_idx  (wb_dest),
        .wr_data (wb_data),
        .rd_data (rf_data)
    );

    // One bypass unit per source operand
    for (genvar i = 0; i < NUM_SRC; i++) begin : g_fwd
        operand_forward u_fwd (
            .src_idx (issue.src_idx[i]),
            .rf_val  (issue.src_val[i]),
            .bypass  (bypass.fwd),
            .operand (operand[i]),
            .stall   (src_stall[i])
        );
    end

    // ============================================================
    // Back end
    // ============================================================
    execute_stage u_execute (
        .clk            (clk),
        .reset          (reset),
        .issue          (issue.exe),
        .operand        (operand),
        .src_stall      (src_stall),
        .bypass         (bypass.ex_src),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .load_use_stall (load_use_stall),
        .mem_ctrl       (mem_ctrl),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_dest       (mem_dest)
    );

    memory_stage u_memory (
        .clk       (clk),
        .reset     (reset),
        .mem_ctrl  (mem_ctrl),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_dest  (mem_dest),
        .bypass    (bypass.mem_src),
        .wb_write  (wb_write),
        .wb_dest   (wb_dest),
        .wb_data   (wb_data)
    );

endmodule

// ==== memory_stage.sv ====
// Data memory access, MEM/WB register and write-back result select
`timescale 1ns/1ps

module memory_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  ctrl_t     mem_ctrl,
    input  word_t     mem_addr,
    input  word_t     mem_wdata,
    input  reg_idx_t  mem_dest,
    bypass_if.mem_src bypass,
    output logic      wb_write,
    output reg_idx_t  wb_dest,
    output word_t     wb_data
);
    word_t              dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_addr;
    word_t              mem_result;

    assign word_addr = mem_addr[DMEM_AW+1:2];   // Word aligned, low bits ignored

    // Store lands at the edge that ends its MEM cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_ctrl.mem_write) begin
            dmem[word_addr] <= mem_wdata;
        end
    end

    // Load reads combinationally
    assign mem_result = mem_ctrl.mem_read ? dmem[word_addr] : mem_addr;

    // ============================================================
    // MEM/WB register
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_write <= 1'b0;
        end else begin
            wb_write <= mem_ctrl.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest <= mem_dest;
        wb_data <= mem_result;
    end

    assign bypass.mem_val  = mem_result;
    assign bypass.wb_dest  = wb_dest;
    assign bypass.wb_write = wb_write;
    assign bypass.wb_val   = wb_data;

endmodule

// ==== execute_stage.sv ====
// ID/EX register, ALU, branch and jump resolution, and EX/MEM register
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    issue_if.exe                 issue,
    input  word_t [NUM_SRC-1:0]  operand,
    input  logic  [NUM_SRC-1:0]  src_stall,
    bypass_if.ex_src             bypass,
    output logic                 redirect,
    output word_t                redirect_pc,
    output logic                 load_use_stall,
    output ctrl_t                mem_ctrl,
    output word_t                mem_addr,
    output word_t                mem_wdata,
    output reg_idx_t             mem_dest
);
    ctrl_t                ex_ctrl;
    word_t                ex_pc_plus4;
    word_t                ex_imm;
    word_t                ex_branch_target;
    word_t                ex_jump_target;
    reg_idx_t             ex_dest;
    word_t [NUM_SRC-1:0]  ex_opnd;
    word_t                alu_b;
    word_t                alu_out;
    logic                 br_taken;

    assign load_use_stall = |src_stall;

    // ============================================================
    // ID/EX register
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset || redirect || load_use_stall) begin
            ex_ctrl <= '0;                  // Bubble
        end else begin
            ex_ctrl <= issue.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc_plus4      <= issue.pc_plus4;
        ex_imm           <= issue.imm;
        ex_branch_target <= issue.branch_target;
        ex_jump_target   <= issue.jump_target;
        ex_dest          <= issue.dest;
        ex_opnd          <= operand;        // Forwarded values
    end

    // ============================================================
    // ALU and branch resolution
    // ============================================================
    assign alu_b = ex_ctrl.use_imm ? ex_imm : ex_opnd[1];

    always_comb begin
        case (ex_ctrl.alu_op)
            ALU_ADD: alu_out = ex_opnd[0] + alu_b;
            ALU_SUB: alu_out = ex_opnd[0] - alu_b;
            ALU_AND: alu_out = ex_opnd[0] & alu_b;
            ALU_OR:  alu_out = ex_opnd[0] | alu_b;
            ALU_SLT: alu_out = {31'b0, $signed(ex_opnd[0]) < $signed(alu_b)};
            ALU_LUI: alu_out = {alu_b[15:0], 16'h0};
            default: alu_out = '0;
        endcase
    end

    assign br_taken = (ex_ctrl.branch_eq && (ex_opnd[0] == ex_opnd[1])) ||
                      (ex_ctrl.branch_ne && (ex_opnd[0] != ex_opnd[1]));
    assign redirect = ex_ctrl.valid && (br_taken || ex_ctrl.jump);  // Bubble follows

    // Resolved next PC of the EX instruction
    assign redirect_pc = ex_ctrl.jump ? ex_jump_target :
                         br_taken     ? ex_branch_target : ex_pc_plus4;

    // ============================================================
    // EX/MEM register
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_ctrl <= '0;
        end else begin
            mem_ctrl <= ex_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        mem_addr  <= alu_out;               // Also the ALU result
        mem_wdata <= ex_opnd[1];            // Store data from rt
        mem_dest  <= ex_dest;
    end

    assign bypass.ex_dest   = ex_dest;
    assign bypass.ex_write  = ex_ctrl.reg_write;
    assign bypass.ex_load   = ex_ctrl.mem_read;
    assign bypass.ex_val    = alu_out;
    assign bypass.mem_dest  = mem_dest;
    assign bypass.mem_write = mem_ctrl.reg_write;

endmodule

// ==== operand_forward.sv ====
// Bypass select and load-use detect for one source operand
`timescale 1ns/1ps

module operand_forward import mips_pkg::*; (
    input  reg_idx_t src_idx,
    input  word_t    rf_val,
    bypass_if.fwd    bypass,
    output word_t    operand,
    output logic     stall
);
    logic ex_hit;
    logic mem_hit;
    logic wb_hit;

    // Register zero never matches
    assign ex_hit  = (src_idx != '0) && bypass.ex_write  && (bypass.ex_dest  == src_idx);
    assign mem_hit = (src_idx != '0) && bypass.mem_write && (bypass.mem_dest == src_idx);
    assign wb_hit  = (src_idx != '0) && bypass.wb_write  && (bypass.wb_dest  == src_idx);

    // Youngest writer first
    always_comb begin
        if (ex_hit) begin
            operand = bypass.ex_val;
        end else if (mem_hit) begin
            operand = bypass.mem_val;       // Load data already selected
        end else if (wb_hit) begin
            operand = bypass.wb_val;        // Same-cycle register write
        end else begin
            operand = rf_val;
        end
    end

    // Load data is not ready until MEM, so hold decode one cycle
    assign stall = ex_hit && bypass.ex_load;

endmodule

// ==== decode_stage.sv ====
// Instruction decode into control fields, immediates, targets and register reads
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
    input  word_t                  id_inst,
    input  word_t                  id_pc_plus4,
    input  logic                   id_valid,
    input  word_t    [NUM_SRC-1:0] rf_data,
    output reg_idx_t [NUM_SRC-1:0] rf_idx,
    issue_if.dec                   issue
);
    opcode_e     opcode;
    funct_e      funct;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    dest;
    logic [15:0] imm16;
    word_t       imm_sext;
    logic        use_rs;
    logic        use_rt;
    logic        zero_ext;
    logic        legal;
    ctrl_t       dec;

    assign opcode   = opcode_e'(id_inst[31:26]);
    assign funct    = funct_e'(id_inst[5:0]);
    assign rs       = id_inst[25:21];
    assign rt       = id_inst[20:16];
    assign imm16    = id_inst[15:0];
    assign imm_sext = {{16{imm16[15]}}, imm16};

    always_comb begin
        dec      = '0;
        use_rs   = 1'b1;                    // Most formats read rs
        use_rt   = 1'b0;
        zero_ext = 1'b0;
        legal    = 1'b1;
        dest     = rt;                      // I-type writes rt
        case (opcode)
            OP_RTYPE: begin
                use_rt        = 1'b1;
                dest          = id_inst[15:11];
                dec.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    default: legal = 1'b0;  // Includes the all-zero no-op
                endcase
            end
            OP_ADDIU: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OP_ANDI: begin
                dec.alu_op    = ALU_AND;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                zero_ext      = 1'b1;
            end
            OP_ORI: begin
                dec.alu_op    = ALU_OR;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                zero_ext      = 1'b1;
            end
            OP_LUI: begin
                use_rs        = 1'b0;
                dec.alu_op    = ALU_LUI;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                zero_ext      = 1'b1;
            end
            OP_LW: begin
                dec.use_imm   = 1'b1;       // Address is rs plus offset
                dec.reg_write = 1'b1;
                dec.mem_read  = 1'b1;
            end
            OP_SW: begin
                use_rt        = 1'b1;       // Store data
                dec.use_imm   = 1'b1;
                dec.mem_write = 1'b1;
            end
            OP_BEQ: begin
                use_rt        = 1'b1;
                dec.branch_eq = 1'b1;
            end
            OP_BNE: begin
                use_rt        = 1'b1;
                dec.branch_ne = 1'b1;
            end
            OP_J: begin
                use_rs   = 1'b0;
                dec.jump = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        dec.valid = legal & id_valid;
        if (!dec.valid) begin
            dec = '0;                       // Invalid decodes as a bubble
        end else if (dest == '0) begin
            dec.reg_write = 1'b0;
        end
    end

    // Unused sources read as register zero, which never forwards or stalls
    assign rf_idx[0] = (use_rs && dec.valid) ? rs : '0;
    assign rf_idx[1] = (use_rt && dec.valid) ? rt : '0;

    assign issue.ctrl          = dec;
    assign issue.pc_plus4      = id_pc_plus4;
    assign issue.imm           = zero_ext ? {16'h0, imm16} : imm_sext;
    assign issue.branch_target = id_pc_plus4 + {imm_sext[29:0], 2'b00};
    assign issue.jump_target   = {id_pc_plus4[31:28], id_inst[25:0], 2'b00};
    assign issue.dest          = dest;
    assign issue.src_idx       = rf_idx;
    assign issue.src_val       = rf_data;

endmodule

// ==== register_file.sv ====
// 32-entry general register file, two combinational reads and one write
`timescale 1ns/1ps

module register_file import mips_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  reg_idx_t [NUM_SRC-1:0] rd_idx,
    input  logic                   wr_en,
    input  reg_idx_t               wr_idx,
    input  word_t                  wr_data,
    output word_t    [NUM_SRC-1:0] rd_data
);
    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;        // Register zero stays zero
        end
    end

    // No write-through, WB bypass covers that cycle
    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            rd_data[i] = (rd_idx[i] == '0) ? '0 : regs[rd_idx[i]];
        end
    end

endmodule

// ==== fetch_stage.sv ====
// Instruction fetch with the PC register and the IF/ID pipeline register
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  redirect,                 // Taken branch or jump in EX
    input  word_t redirect_pc,
    input  logic  load_use_stall,
    input  word_t imem_data,
    output word_t imem_addr,
    output word_t id_inst,
    output word_t id_pc_plus4,
    output logic  id_valid
);
    word_t pc;
    word_t pc_plus4;

    assign imem_addr = pc;                  // Combinational instruction port
    assign pc_plus4  = pc + 32'd4;          // Predict not taken

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;              // Redirect wins over stall
        end else if (!load_use_stall) begin
            pc <= pc_plus4;
        end
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            id_valid <= 1'b0;               // Drop the wrong-path fetch
        end else if (!load_use_stall) begin
            id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!load_use_stall) begin
            id_inst     <= imem_data;
            id_pc_plus4 <= pc_plus4;
        end
    end

endmodule

// ==== pipe_ifs.sv ====
// Decode-to-execute issue bundle and the in-flight result bypass bundle
`timescale 1ns/1ps

interface issue_if import mips_pkg::*; ();
    ctrl_t                   ctrl;
    word_t                   pc_plus4;
    word_t                   imm;               // Already sign or zero extended
    word_t                   branch_target;
    word_t                   jump_target;
    reg_idx_t                dest;
    reg_idx_t [NUM_SRC-1:0]  src_idx;           // Zero when the operand is unused
    word_t    [NUM_SRC-1:0]  src_val;           // Raw register file values

    modport dec (output ctrl, pc_plus4, imm, branch_target, jump_target, dest, src_idx, src_val);
    modport exe (input ctrl, pc_plus4, imm, branch_target, jump_target, dest);
endinterface

interface bypass_if import mips_pkg::*; ();
    reg_idx_t ex_dest;
    logic     ex_write;
    logic     ex_load;                          // EX value is only an address
    word_t    ex_val;
    reg_idx_t mem_dest;
    logic     mem_write;
    word_t    mem_val;
    reg_idx_t wb_dest;
    logic     wb_write;
    word_t    wb_val;

    modport ex_src  (output ex_dest, ex_write, ex_load, ex_val, mem_dest, mem_write);
    modport mem_src (output mem_val, wb_dest, wb_write, wb_val);
    modport fwd     (input ex_dest, ex_write, ex_load, ex_val, mem_dest, mem_write,
                     mem_val, wb_dest, wb_write, wb_val);
endinterface

// ==== mips_pkg.sv ====
// MIPS core package with widths, opcode and ALU enums, and decoded control fields
package mips_pkg;

    // ============================================================
    // Widths and sizes
    // ============================================================
    typedef logic [31:0] word_t;            // Data or address word
    typedef logic [4:0]  reg_idx_t;         // Register number

    localparam int NUM_SRC    = 2;          // rs and rt
    localparam int DMEM_WORDS = 256;        // Data memory depth
    localparam int DMEM_AW    = 8;          // Word address width

    // ============================================================
    // Encodings
    // ============================================================
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,                            // Also address generation
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,                            // Signed compare
        ALU_LUI                             // Immediate into upper half
    } alu_op_e;

    typedef struct packed {
        logic    valid;                     // Real instruction, not a bubble
        alu_op_e alu_op;
        logic    use_imm;                   // Second ALU operand is the immediate
        logic    reg_write;                 // Never set for register zero
        logic    mem_read;
        logic    mem_write;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
    } ctrl_t;

endpackage
